// File: all.f
source/rst_pkg.sv
source/reset_timer.sv
source/reset_sequencer.sv
source/activity_led.sv
source/board_reset_ctrl.sv
verif/tb_clock_gen.sv
verif/board_reset_ctrl_assert.sv
verif/tb_board_reset_ctrl.sv

// File: run.sh
#!/bin/sh
# build the board reset testbench with Verilator, run it and look for the pass message
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module tb_board_reset_ctrl -f all.f \
	&& ./obj_dir/Vtb_board_reset_ctrl | tee /dev/stderr | grep -q "Result: PASSED" \
	&& echo "simulation passed" \
	|| { echo "simulation failed"; exit 1; }

// File: source/activity_led.sv
`timescale 1ns/10ps
// activity LED: throttled one-cycle activity pulse merged onto GPIO bit 0
module activity_led import rst_pkg::*; #(
	parameter int WIDTH = DEF_ACT_CNTR_BITSZ
) (
	input  logic  clk100mhz_i,
	input  logic  rst_p,
	input  logic  sd_di_i,
	input  logic  sd_do_i,
	input  logic  dram_init_error_i,
	input  gpio_t gpio_i,
	output gpio_t gp_o
);

	logic             event_w;
	logic [WIDTH-1:0] dim_cnt_q;
	logic             pulse_q;

	// SPI lines idle high, so any low line means traffic
	// a DRAM init error keeps the LED flashing
	assign event_w = ~(sd_di_i & sd_do_i) | dram_init_error_i;

	always_ff @(posedge clk100mhz_i) begin
		if (rst_p) begin
			dim_cnt_q <= '0;
			pulse_q   <= 1'b0;
		end else if (dim_cnt_q != '0) begin
			// blanking period, no pulse until the counter empties
			dim_cnt_q <= dim_cnt_q - 1'b1;
			pulse_q   <= 1'b0;
		end else if (event_w) begin
			dim_cnt_q <= '1;
			pulse_q   <= 1'b1;
		end else begin
			pulse_q <= 1'b0;
		end
	end

	// only bit 0 carries the activity indication
	assign gp_o = gpio_i | {{(GPIO_COUNT-1){1'b0}}, pulse_q};

endmodule

// File: source/board_reset_ctrl.sv
`timescale 1ns/10ps
// board reset control: system and RAM reset stretching, software reset decode and activity LED
module board_reset_ctrl import rst_pkg::*; #(
	parameter int RST_CNTR_BITSZ = DEF_RST_CNTR_BITSZ,
	parameter int ACT_CNTR_BITSZ = DEF_ACT_CNTR_BITSZ
) (
	input  logic        clk100mhz_i,
	input  logic        rst_p,
	input  logic        pll_locked_i,
	input  logic        cpu_rst_req_i,
	input  sw_rst_cmd_e sw_rst_cmd_i,
	input  logic        dram_init_error_i,
	input  logic        sd_di_i,
	input  logic        sd_do_i,
	input  gpio_t       gpio_i,
	output logic        sys_rst_o,
	output logic        ram_rst_o,
	output logic        sd_reset_o,
	output logic        cold_rst_o,
	output gpio_t       gp_o
);

	logic sys_reload;
	logic sys_run;
	logic sys_busy;
	logic ram_reload;
	logic ram_run;
	logic ram_busy;

	reset_sequencer u_sequencer (
		.clk100mhz_i   (clk100mhz_i),
		.rst_p         (rst_p),
		.pll_locked_i  (pll_locked_i),
		.cpu_rst_req_i (cpu_rst_req_i),
		.sw_rst_cmd_i  (sw_rst_cmd_i),
		.sys_busy_i    (sys_busy),
		.ram_busy_i    (ram_busy),
		.sys_reload_o  (sys_reload),
		.sys_run_o     (sys_run),
		.ram_reload_o  (ram_reload),
		.ram_run_o     (ram_run),
		.sys_rst_o     (sys_rst_o),
		.ram_rst_o     (ram_rst_o),
		.cold_rst_o    (cold_rst_o)
	);

	// stretches the system reset after the last cause
	reset_timer #(
		.WIDTH (RST_CNTR_BITSZ)
	) u_sys_timer (
		.clk100mhz_i (clk100mhz_i),
		.reload_i    (sys_reload),
		.run_i       (sys_run),
		.busy_o      (sys_busy)
	);

	// stretches the DRAM controller reset
	reset_timer #(
		.WIDTH (RST_CNTR_BITSZ)
	) u_ram_timer (
		.clk100mhz_i (clk100mhz_i),
		.reload_i    (ram_reload),
		.run_i       (ram_run),
		.busy_o      (ram_busy)
	);

	activity_led #(
		.WIDTH (ACT_CNTR_BITSZ)
	) u_activity_led (
		.clk100mhz_i       (clk100mhz_i),
		.rst_p             (rst_p),
		.sd_di_i           (sd_di_i),
		.sd_do_i           (sd_do_i),
		.dram_init_error_i (dram_init_error_i),
		.gpio_i            (gpio_i),
		.gp_o              (gp_o)
	);

	// SD card power is cut for as long as the system is in reset
	assign sd_reset_o = sys_rst_o;

endmodule

// File: source/reset_sequencer.sv
`timescale 1ns/10ps
// reset sequencer: decodes reset causes, steers both reset timers and forms the board resets
module reset_sequencer import rst_pkg::*; (
	input  logic        clk100mhz_i,
	input  logic        rst_p,
	input  logic        pll_locked_i,
	input  logic        cpu_rst_req_i,
	input  sw_rst_cmd_e sw_rst_cmd_i,
	input  logic        sys_busy_i,
	input  logic        ram_busy_i,
	output logic        sys_reload_o,
	output logic        sys_run_o,
	output logic        ram_reload_o,
	output logic        ram_run_o,
	output logic        sys_rst_o,
	output logic        ram_rst_o,
	output logic        cold_rst_o
);

	// HOLD   a reset cause is present
	// COUNT  the system timer is draining
	// RUN    the system is out of reset
	// OFF    power-off latched, only rst_p leaves
	typedef enum logic [1:0] {
		ST_HOLD  = 2'd0,
		ST_COUNT = 2'd1,
		ST_RUN   = 2'd2,
		ST_OFF   = 2'd3
	} seq_state_e;

	seq_state_e state_q;
	seq_state_e state_d;

	logic warm_cmd;
	logic cold_cmd;
	logic off_cmd;
	logic sys_cause;
	logic cold_q;

	// software command decode
	assign warm_cmd = (sw_rst_cmd_i == SW_RST_WARM);
	assign cold_cmd = (sw_rst_cmd_i == SW_RST_COLD);
	assign off_cmd  = (sw_rst_cmd_i == SW_RST_OFF);

	// anything that restarts the system reset stretch
	assign sys_cause = rst_p | cpu_rst_req_i | warm_cmd | cold_cmd;

	always_comb begin
		state_d = state_q;
		case (state_q)
			ST_HOLD: begin
				// timer was reloaded while here, start draining once clear
				if (!sys_cause) begin
					state_d = ST_COUNT;
				end
			end
			ST_COUNT: begin
				if (sys_cause) begin
					state_d = ST_HOLD;
				end else if (pll_locked_i && !sys_busy_i) begin
					state_d = ST_RUN;
				end
			end
			ST_RUN: begin
				if (sys_cause) begin
					state_d = ST_HOLD;
				end else if (!pll_locked_i) begin
					// lost lock, wait for it again before running
					state_d = ST_COUNT;
				end
			end
			ST_OFF: begin
				state_d = ST_OFF;
			end
		endcase

		// a power-off request overrides every state
		if (off_cmd) begin
			state_d = ST_OFF;
		end
	end

	always_ff @(posedge clk100mhz_i) begin
		if (rst_p) begin
			state_q <= ST_HOLD;
		end else begin
			state_q <= state_d;
		end
	end

	// cold restart strobe, one cycle behind the command
	always_ff @(posedge clk100mhz_i) begin
		if (rst_p) begin
			cold_q <= 1'b0;
		end else begin
			cold_q <= cold_cmd;
		end
	end

	// system timer reloads on any cause
	assign sys_reload_o = sys_cause;

	// drain only in COUNT and only with a stable clock
	assign sys_run_o = pll_locked_i & (state_q == ST_COUNT);

	// RAM contents survive warm restarts,
	// so only board reset or a cold restart reloads this timer
	assign ram_reload_o = rst_p | cold_cmd;
	assign ram_run_o    = pll_locked_i;

	// board resets
	assign sys_rst_o  = sys_busy_i | ~pll_locked_i | (state_q == ST_OFF);
	assign ram_rst_o  = ram_busy_i;
	assign cold_rst_o = cold_q;

endmodule

// File: source/reset_timer.sv
`timescale 1ns/10ps
// reset timer: reloadable down-counter that keeps a reset asserted until it runs out
module reset_timer import rst_pkg::*; #(
	parameter int WIDTH = DEF_RST_CNTR_BITSZ
) (
	input  logic clk100mhz_i,
	input  logic reload_i,
	input  logic run_i,
	output logic busy_o
);

	// remaining reset cycles
	logic [WIDTH-1:0] cnt_q;

	// reload wins over counting, so a cause that is
	// still present keeps the count pinned at full scale
	always_ff @(posedge clk100mhz_i) begin
		if (reload_i) begin
			cnt_q <= '1;
		end else if (run_i && (cnt_q != '0)) begin
			cnt_q <= cnt_q - 1'b1;
		end
	end

	// stays busy until the last decrement lands on zero
	assign busy_o = |cnt_q;

endmodule

// File: source/rst_pkg.sv
// reset control package: software reset command encoding, GPIO bus type and counter defaults
package rst_pkg;

	// software reset command as driven by the device table
	// high bit alone asks for a warm restart, low bit alone for power off,
	// both bits together for a cold restart
	typedef enum logic [1:0] {
		SW_RST_NONE = 2'b00,
		SW_RST_OFF  = 2'b01,
		SW_RST_WARM = 2'b10,
		SW_RST_COLD = 2'b11
	} sw_rst_cmd_e;

	// number of GPIO lines on the board header
	localparam int GPIO_COUNT = 8;

	// GPIO bus as seen by the activity merge
	typedef logic [GPIO_COUNT-1:0] gpio_t;

	// reset stretch counter width
	// 16 bits gives about 655 us at 100 MHz
	localparam int DEF_RST_CNTR_BITSZ = 16;

	// activity dimming counter width
	// one bit lights the LED at most every other cycle
	localparam int DEF_ACT_CNTR_BITSZ = 1;

endpackage

// File: verif/board_reset_ctrl_assert.sv
`timescale 1ns/10ps
// reset sequencer checks: power-off hold, SD card reset copy and cold restart after reset
module board_reset_ctrl_assert (
	input logic       clk100mhz_i,
	input logic       rst_p,
	input logic [1:0] state_i,
	input logic       sys_rst_i,
	input logic       sd_reset_i,
	input logic       cold_rst_i
);

	// encoding of OFF inside the sequencer FSM
	localparam logic [1:0] OFF_STATE = 2'd3;

	int fail_count = 0;

	// latched power-off keeps the whole board in reset
	a_off_holds_reset: assert property (@(posedge clk100mhz_i)
		(state_i == OFF_STATE) |-> sys_rst_i)
		else begin
			fail_count++;
			$error("system reset released while power-off is latched");
		end

	// SD card reset seen at the top level tracks the system reset
	a_sd_follows_sys: assert property (@(posedge clk100mhz_i)
		sd_reset_i == sys_rst_i)
		else begin
			fail_count++;
			$error("SD card reset differs from the system reset");
		end

	a_no_cold_after_reset: assert property (@(posedge clk100mhz_i)
		rst_p |=> !cold_rst_i)
		else begin
			fail_count++;
			$error("cold restart output high in the cycle after reset");
		end

endmodule

// File: verif/tb_board_reset_ctrl.sv
`timescale 1ns/10ps
// testbench for the board reset controller: directed reset, power-off and activity tests
module tb_board_reset_ctrl import rst_pkg::*; ();

	localparam int RST_BITS     = 5;
	localparam int ACT_BITS     = 2;
	localparam int REL_MIN      = (1 << RST_BITS) - 1;
	localparam int REL_MAX      = (1 << RST_BITS) + 1;
	localparam int REL_LIMIT    = 4 * (1 << RST_BITS);
	localparam int PULSE_PERIOD = 1 << ACT_BITS;

	logic        clk100mhz;
	logic        por_rst;
	logic        tb_rst;
	logic        rst_p;
	logic        pll_locked;
	logic        cpu_rst_req;
	sw_rst_cmd_e sw_rst_cmd;
	logic        dram_init_error;
	logic        sd_di;
	logic        sd_do;
	gpio_t       gpio;
	logic        sys_rst;
	logic        ram_rst;
	logic        sd_reset;
	logic        cold_rst;
	gpio_t       gp;

	int error_count = 0;
	int check_count = 0;

	tb_clock_gen #(
		.PERIOD_NS  (10),
		.RST_CYCLES (16)
	) u_clock_gen (
		.clk100mhz_o (clk100mhz),
		.rst_p_o     (por_rst)
	);

	// power-on reset plus the pulses issued by the tests
	assign rst_p = por_rst | tb_rst;

	board_reset_ctrl #(
		.RST_CNTR_BITSZ (RST_BITS),
		.ACT_CNTR_BITSZ (ACT_BITS)
	) u_board_reset_ctrl (
		.clk100mhz_i       (clk100mhz),
		.rst_p             (rst_p),
		.pll_locked_i      (pll_locked),
		.cpu_rst_req_i     (cpu_rst_req),
		.sw_rst_cmd_i      (sw_rst_cmd),
		.dram_init_error_i (dram_init_error),
		.sd_di_i           (sd_di),
		.sd_do_i           (sd_do),
		.gpio_i            (gpio),
		.sys_rst_o         (sys_rst),
		.ram_rst_o         (ram_rst),
		.sd_reset_o        (sd_reset),
		.cold_rst_o        (cold_rst),
		.gp_o              (gp)
	);

	bind reset_sequencer board_reset_ctrl_assert u_seq_assert (
		.clk100mhz_i  (clk100mhz_i),
		.rst_p        (rst_p),
		.state_i      (state_q),
		.sys_rst_i    (sys_rst_o),
		.sd_reset_i   (u_board_reset_ctrl.sd_reset_o),
		.cold_rst_i   (cold_rst_o)
	);

	task automatic compare_logic(input string name, input logic got, input logic exp);
		check_count++;
		if (got !== exp) begin
			error_count++;
			$display("FAIL t=%0t %s got=%b exp=%b", $time, name, got, exp);
		end
	endtask

	task automatic compare_gpio(input string name, input gpio_t got, input gpio_t exp);
		check_count++;
		if (got !== exp) begin
			error_count++;
			$display("FAIL t=%0t %s got=%h exp=%h", $time, name, got, exp);
		end
	endtask

	// release must land within one cycle either side of the full count
	task automatic check_window(input string name, input int cycles);
		check_count++;
		if (cycles >= 0 && (cycles < REL_MIN || cycles > REL_MAX)) begin
			error_count++;
			$display("FAIL t=%0t %s released after %0d cycles exp=%0d..%0d",
				$time, name, cycles, REL_MIN, REL_MAX);
		end
	endtask

	// counts falling edges until each reset output is low
	task automatic await_release(output int sys_cycles, output int ram_cycles);
		int n;
		n = 0;
		sys_cycles = -1;
		ram_cycles = -1;
		while ((sys_cycles < 0 || ram_cycles < 0) && n < REL_LIMIT) begin
			@(negedge clk100mhz);
			n++;
			if (sys_cycles < 0 && sys_rst === 1'b0) begin
				sys_cycles = n;
			end
			if (ram_cycles < 0 && ram_rst === 1'b0) begin
				ram_cycles = n;
			end
		end
		if (sys_cycles < 0 || ram_cycles < 0) begin
			error_count++;
			$display("timeout: a reset output was still high after %0d cycles", REL_LIMIT);
		end
	endtask

	// SD card reset is a plain copy of the system reset
	always @(negedge clk100mhz) begin
		compare_logic("sd_reset_o", sd_reset, sys_rst);
	end

	task automatic test_power_up();
		int n;
		int sys_n;
		int ram_n;
		n = 0;
		while (por_rst !== 1'b0 && n < 64) begin
			@(posedge clk100mhz);
			n++;
		end
		if (por_rst !== 1'b0) begin
			error_count++;
			$display("power-on reset was never released");
		end
		repeat (10 + ($urandom % 20)) begin
			@(negedge clk100mhz);
			compare_logic("sys_rst_o", sys_rst, 1'b1);
			compare_logic("ram_rst_o", ram_rst, 1'b1);
			compare_logic("cold_rst_o", cold_rst, 1'b0);
			compare_gpio("gp_o", gp, gpio);
		end
		pll_locked = 1'b1;
		await_release(sys_n, ram_n);
		check_window("sys_rst_o", sys_n);
		check_window("ram_rst_o", ram_n);
	endtask

	// kind 0 is the CPU request, 1 the warm command, 2 the board reset
	task automatic drive_cause(input int kind, input logic level);
		case (kind)
			0: cpu_rst_req = level;
			1: sw_rst_cmd = level ? SW_RST_WARM : SW_RST_NONE;
			default: tb_rst = level;
		endcase
	endtask

	task automatic test_sys_causes();
		int kind;
		int sys_n;
		int ram_n;
		for (kind = 0; kind < 3; kind++) begin
			@(negedge clk100mhz);
			drive_cause(kind, 1'b1);
			repeat (2 + ($urandom % 6)) begin
				@(negedge clk100mhz);
				compare_logic("sys_rst_o", sys_rst, 1'b1);
				compare_logic("ram_rst_o", ram_rst, (kind == 2));
			end
			drive_cause(kind, 1'b0);
			await_release(sys_n, ram_n);
			check_window("sys_rst_o", sys_n);
			if (kind == 2) begin
				check_window("ram_rst_o", ram_n);
			end else begin
				compare_logic("ram_rst_o", ram_rst, 1'b0);
			end
		end
	endtask

	task automatic test_power_off();
		int i;
		int sys_n;
		int ram_n;
		@(negedge clk100mhz);
		sw_rst_cmd = SW_RST_OFF;
		@(negedge clk100mhz);
		compare_logic("sys_rst_o", sys_rst, 1'b1);
		sw_rst_cmd = SW_RST_NONE;
		for (i = 0; i < 200; i++) begin
			@(negedge clk100mhz);
			if (sys_rst !== 1'b1) begin
				compare_logic("sys_rst_o", sys_rst, 1'b1);
				break;
			end
		end
		compare_logic("ram_rst_o", ram_rst, 1'b0);
		// only a board reset brings it back
		tb_rst = 1'b1;
		repeat (3) begin
			@(negedge clk100mhz);
			compare_logic("sys_rst_o", sys_rst, 1'b1);
			compare_logic("ram_rst_o", ram_rst, 1'b1);
		end
		tb_rst = 1'b0;
		await_release(sys_n, ram_n);
		check_window("sys_rst_o", sys_n);
		check_window("ram_rst_o", ram_n);
	endtask

	task automatic test_cold_restart();
		int sys_n;
		int ram_n;
		@(negedge clk100mhz);
		sw_rst_cmd = SW_RST_COLD;
		compare_logic("cold_rst_o", cold_rst, 1'b0);
		repeat (1 + ($urandom % 4)) begin
			@(negedge clk100mhz);
			compare_logic("cold_rst_o", cold_rst, 1'b1);
			compare_logic("sys_rst_o", sys_rst, 1'b1);
			compare_logic("ram_rst_o", ram_rst, 1'b1);
		end
		sw_rst_cmd = SW_RST_NONE;
		await_release(sys_n, ram_n);
		check_window("sys_rst_o", sys_n);
		check_window("ram_rst_o", ram_n);
		compare_logic("cold_rst_o", cold_rst, 1'b0);
	endtask

	task automatic test_activity();
		int i;
		gpio_t exp;
		// no events, gp_o is a straight copy
		for (i = 0; i < 12; i++) begin
			@(negedge clk100mhz);
			compare_gpio("gp_o", gp, gpio);
			gpio = gpio_t'($urandom);
		end
		gpio[0] = 1'b0;
		sd_di = 1'b0;
		// steady traffic, one pulse per dimming period
		for (i = 0; i < 6 * PULSE_PERIOD; i++) begin
			@(negedge clk100mhz);
			exp = gpio;
			exp[0] = ((i % PULSE_PERIOD) == 0);
			compare_gpio("gp_o", gp, exp);
			gpio = gpio_t'($urandom);
			gpio[0] = 1'b0;
		end
		sd_di = 1'b1;
		for (i = 0; i < 20; i++) begin
			@(negedge clk100mhz);
			compare_gpio("gp_o", gp, gpio);
			gpio = gpio_t'($urandom);
			gpio[0] = 1'b0;
		end
		// single events after idle gaps long enough to empty the counter
		for (i = 0; i < 4; i++) begin
			repeat (PULSE_PERIOD + ($urandom % 6)) begin
				@(negedge clk100mhz);
				compare_logic("gp_o[0]", gp[0], 1'b0);
			end
			if (i % 2 == 0) begin
				dram_init_error = 1'b1;
			end else begin
				sd_do = 1'b0;
			end
			@(negedge clk100mhz);
			compare_logic("gp_o[0]", gp[0], 1'b1);
			dram_init_error = 1'b0;
			sd_do = 1'b1;
		end
	endtask

	initial begin
		int assert_fails;
		tb_rst          = 1'b0;
		pll_locked      = 1'b0;
		cpu_rst_req     = 1'b0;
		sw_rst_cmd      = SW_RST_NONE;
		dram_init_error = 1'b0;
		sd_di           = 1'b1;
		sd_do           = 1'b1;
		gpio            = '0;
		void'($urandom(32'hcb2b));

		test_power_up();
		test_sys_causes();
		test_power_off();
		test_cold_restart();
		test_activity();

		repeat (2) @(negedge clk100mhz);
		assert_fails = u_board_reset_ctrl.u_sequencer.u_seq_assert.fail_count;
		$display("checks %0d, errors %0d, assertion failures %0d",
			check_count, error_count, assert_fails);
		if (error_count == 0 && assert_fails == 0) begin
			$display("Result: PASSED");
		end else begin
			$display("Result: FAILED");
		end
		$finish;
	end

endmodule

// File: verif/tb_clock_gen.sv
`timescale 1ns/10ps
// testbench clock and power-on reset generator
module tb_clock_gen #(
	parameter int PERIOD_NS  = 10,
	parameter int RST_CYCLES = 16
) (
	output logic clk100mhz_o,
	output logic rst_p_o
);

	initial begin
		clk100mhz_o = 1'b0;
		forever #(PERIOD_NS / 2) clk100mhz_o = ~clk100mhz_o;
	end

	// released on a falling edge like every other stimulus
	initial begin
		rst_p_o = 1'b1;
		repeat (RST_CYCLES) @(posedge clk100mhz_o);
		@(negedge clk100mhz_o);
		rst_p_o = 1'b0;
	end

endmodule
